//--- cpuCore.f
rtl/cpuPkg.sv
rtl/programCounter.sv
rtl/instructionDecoder.sv
rtl/registerFile.sv
rtl/lookaheadAdder.sv
rtl/alu.sv
rtl/cpuCore.sv
tests/cpuCoreChecker.sv
tests/cpuCoreTb.sv

//--- rtl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
(
    input  cpuPkg::aluOpT                aluOp,
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    output logic [cpuPkg::dataWidth-1:0] result
);
    import cpuPkg::*;

    logic                  subtract;
    logic [dataWidth-1:0]  addend;
    logic [dataWidth-1:0]  sum;
    logic [shiftWidth-1:0] shiftAmount;

    // Subtract as a + ~b + 1
    assign subtract    = (aluOp == aluSub);
    assign addend      = subtract ? ~b : b;
    assign shiftAmount = b[shiftWidth-1:0];

    lookaheadAdder adder_i
    (
        .a       (a),
        .b       (addend),
        .carryIn (subtract),
        .sum     (sum)
    );

    always_comb
    begin
        case (aluOp)
            aluAdd,
            aluSub: result = sum;
            aluAnd: result = a & b;
            aluOrr: result = a | b;
            aluEor: result = a ^ b;
            aluLsl: result = a << shiftAmount;
            aluLsr: result = a >> shiftAmount;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/cpuCore.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCore
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [cpuPkg::instWidth-1:0] ibus,
    output logic [cpuPkg::instWidth-1:0] iaddrbus,
    output logic [cpuPkg::dataWidth-1:0] daddrbus,
    output logic [cpuPkg::dataWidth-1:0] dataOut,
    input  logic [cpuPkg::dataWidth-1:0] dataIn,
    output logic                         memWrite
);
    import cpuPkg::*;

    logic [instWidth-1:0]     ifIdInst;
    logic                     decValid;
    aluOpT                    decAluOp;
    logic                     decUseImm;
    logic                     decMemRead;
    logic                     decMemWrite;
    logic                     decRegWrite;
    logic [regIndexWidth-1:0] decRn;
    logic [regIndexWidth-1:0] decRm;
    logic [regIndexWidth-1:0] decRd;
    logic [dataWidth-1:0]     decImm;
    logic [dataWidth-1:0]     readDataA;
    logic [dataWidth-1:0]     readDataB;
    logic [dataWidth-1:0]     aluB;
    logic [dataWidth-1:0]     aluResult;
    idExT                     idEx;
    exMemT                    exMem;
    memWbT                    memWb;

    programCounter pc_i
    (
        .clk   (clk),
        .reset (reset),
        .pc    (iaddrbus)
    );

    // IF/ID, cleared to an all-zero bubble
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ifIdInst <= '0;
        end
        else
        begin
            ifIdInst <= ibus;
        end
    end

    instructionDecoder decoder_i
    (
        .inst     (ifIdInst),
        .valid    (decValid),
        .aluOp    (decAluOp),
        .useImm   (decUseImm),
        .memRead  (decMemRead),
        .memWrite (decMemWrite),
        .regWrite (decRegWrite),
        .rn       (decRn),
        .rm       (decRm),
        .rd       (decRd),
        .imm      (decImm)
    );

    registerFile regFile_i
    (
        .clk         (clk),
        .readA       (decRn),
        .readB       (decRm),
        .dataA       (readDataA),
        .dataB       (readDataB),
        .writeEnable (memWb.regWrite),
        .writeIndex  (memWb.rd),
        .writeData   (memWb.value)
    );

    // Control fields cleared on reset, operands flow freely
    always_ff @(posedge clk)
    begin
        idEx <= '{decValid, decAluOp, decUseImm, decMemRead, decMemWrite, decRegWrite,
                  decRd, readDataA, readDataB, readDataB, decImm};
        if (reset)
        begin
            idEx.valid    <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.regWrite <= 1'b0;
        end
    end

    assign aluB = idEx.useImm ? idEx.imm : idEx.b;

    alu alu_i
    (
        .aluOp  (idEx.aluOp),
        .a      (idEx.a),
        .b      (aluB),
        .result (aluResult)
    );

    always_ff @(posedge clk)
    begin
        exMem <= '{idEx.valid, idEx.memRead, idEx.memWrite, idEx.regWrite,
                   idEx.rd, aluResult, idEx.storeData};
        if (reset)
        begin
            exMem.valid    <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.regWrite <= 1'b0;
        end
    end

    // Memory stage drives the data port
    assign daddrbus = exMem.result;
    assign dataOut  = exMem.storeData;
    assign memWrite = exMem.valid & exMem.memWrite;

    // Load data is sampled at the end of MEM
    always_ff @(posedge clk)
    begin
        memWb.rd    <= exMem.rd;
        memWb.value <= exMem.memRead ? dataIn : exMem.result;
        if (reset)
        begin
            memWb.regWrite <= 1'b0;
        end
        else
        begin
            memWb.regWrite <= exMem.valid & exMem.regWrite;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int dataWidth     = 64;
    localparam int instWidth     = 32;
    localparam int regCount      = 32;
    localparam int regIndexWidth = 5;
    localparam int opcodeWidth   = 11;
    localparam int shiftWidth    = $clog2(dataWidth);
    localparam int adderLevels   = $clog2(dataWidth);

    // XZR
    localparam logic [regIndexWidth-1:0] zeroReg = 5'd31;

    // One instruction word in bytes
    localparam logic [instWidth-1:0] pcStep = 32'd4;

    // R-format
    localparam logic [opcodeWidth-1:0] opAdd  = 11'b10001011000;
    localparam logic [opcodeWidth-1:0] opSub  = 11'b11001011000;
    localparam logic [opcodeWidth-1:0] opAnd  = 11'b10001010000;
    localparam logic [opcodeWidth-1:0] opOrr  = 11'b10101010000;
    localparam logic [opcodeWidth-1:0] opEor  = 11'b11001010000;
    localparam logic [opcodeWidth-1:0] opLsl  = 11'b11010011011;
    localparam logic [opcodeWidth-1:0] opLsr  = 11'b11010011010;

    // I-format, only the top ten bits are significant
    localparam logic [opcodeWidth-1:0] opAddi = 11'b10010001000;
    localparam logic [opcodeWidth-1:0] opSubi = 11'b11010001000;
    localparam logic [opcodeWidth-1:0] opAndi = 11'b10010010000;
    localparam logic [opcodeWidth-1:0] opOrri = 11'b10110010000;
    localparam logic [opcodeWidth-1:0] opEori = 11'b11010010000;

    // D-format
    localparam logic [opcodeWidth-1:0] opLdur = 11'b11111000010;
    localparam logic [opcodeWidth-1:0] opStur = 11'b11111000000;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOrr,
        aluEor,
        aluLsl,
        aluLsr
    } aluOpT;

    typedef struct packed {
        logic                     valid;
        aluOpT                    aluOp;
        logic                     useImm;
        logic                     memRead;
        logic                     memWrite;
        logic                     regWrite;
        logic [regIndexWidth-1:0] rd;
        logic [dataWidth-1:0]     a;
        logic [dataWidth-1:0]     b;
        logic [dataWidth-1:0]     storeData;
        logic [dataWidth-1:0]     imm;
    } idExT;

    typedef struct packed {
        logic                     valid;
        logic                     memRead;
        logic                     memWrite;
        logic                     regWrite;
        logic [regIndexWidth-1:0] rd;
        logic [dataWidth-1:0]     result;
        logic [dataWidth-1:0]     storeData;
    } exMemT;

    typedef struct packed {
        logic                     regWrite;
        logic [regIndexWidth-1:0] rd;
        logic [dataWidth-1:0]     value;
    } memWbT;

endpackage

`default_nettype wire

//--- rtl/instructionDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module instructionDecoder
(
    input  logic [cpuPkg::instWidth-1:0]     inst,
    output logic                             valid,
    output cpuPkg::aluOpT                    aluOp,
    output logic                             useImm,
    output logic                             memRead,
    output logic                             memWrite,
    output logic                             regWrite,
    output logic [cpuPkg::regIndexWidth-1:0] rn,
    output logic [cpuPkg::regIndexWidth-1:0] rm,
    output logic [cpuPkg::regIndexWidth-1:0] rd,
    output logic [cpuPkg::dataWidth-1:0]     imm
);
    import cpuPkg::*;

    logic [opcodeWidth-1:0] opcode;

    assign opcode = inst[31:21];
    assign rn     = inst[9:5];
    assign rd     = inst[4:0];

    // STUR reads rt on the second port
    assign rm = (opcode == opStur) ? inst[4:0] : inst[20:16];

    always_comb
    begin
        valid    = 1'b1;
        aluOp    = aluAdd;
        useImm   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b1;
        // Shift amount unless a format below overrides it
        imm      = {{(dataWidth-6){1'b0}}, inst[15:10]};
        case (opcode)
            opAdd: aluOp = aluAdd;
            opSub: aluOp = aluSub;
            opAnd: aluOp = aluAnd;
            opOrr: aluOp = aluOrr;
            opEor: aluOp = aluEor;
            opLsl:
            begin
                aluOp  = aluLsl;
                useImm = 1'b1;
            end
            opLsr:
            begin
                aluOp  = aluLsr;
                useImm = 1'b1;
            end
            opLdur:
            begin
                useImm  = 1'b1;
                memRead = 1'b1;
                imm     = {{(dataWidth-9){inst[20]}}, inst[20:12]};
            end
            opStur:
            begin
                useImm   = 1'b1;
                memWrite = 1'b1;
                regWrite = 1'b0;
                imm      = {{(dataWidth-9){inst[20]}}, inst[20:12]};
            end
            default:
            begin
                // I-format, bit 21 belongs to the immediate
                useImm = 1'b1;
                imm    = {{(dataWidth-12){1'b0}}, inst[21:10]};
                case (opcode[10:1])
                    opAddi[10:1]: aluOp = aluAdd;
                    opSubi[10:1]: aluOp = aluSub;
                    opAndi[10:1]: aluOp = aluAnd;
                    opOrri[10:1]: aluOp = aluOrr;
                    opEori[10:1]: aluOp = aluEor;
                    default:
                    begin
                        // Bubble
                        valid    = 1'b0;
                        regWrite = 1'b0;
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/lookaheadAdder.sv
`timescale 1ns/100ps
`default_nettype none

module lookaheadAdder
(
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  logic                         carryIn,
    output logic [cpuPkg::dataWidth-1:0] sum
);
    import cpuPkg::*;

    // Level 0 is the bit cells, every later level doubles the group span
    wire [adderLevels:0][dataWidth-1:0] gen;
    wire [adderLevels:0][dataWidth-1:0] prop;
    wire [dataWidth-1:0]                carry;

    assign prop[0] = a ^ b;
    // Carry-in folded into the bit 0 generate
    assign gen[0]  = (a & b) | {{(dataWidth-1){1'b0}}, prop[0][0] & carryIn};

    for (genvar lvl = 1; lvl <= adderLevels; lvl++)
    begin : gLevel
        for (genvar i = 0; i < dataWidth; i++)
        begin : gBit
            if (i >= (1 << (lvl - 1)))
            begin : gMerge
                assign gen[lvl][i]  = gen[lvl-1][i] |
                                      (prop[lvl-1][i] & gen[lvl-1][i-(1 << (lvl-1))]);
                assign prop[lvl][i] = prop[lvl-1][i] & prop[lvl-1][i-(1 << (lvl-1))];
            end
            else
            begin : gPass
                // Group already reaches bit 0
                assign gen[lvl][i]  = gen[lvl-1][i];
                assign prop[lvl][i] = prop[lvl-1][i];
            end
        end
    end

    // Group generate through bit i is the carry into bit i+1
    assign carry = {gen[adderLevels][dataWidth-2:0], carryIn};
    assign sum   = prop[0] ^ carry;

endmodule

`default_nettype wire

//--- rtl/programCounter.sv
`timescale 1ns/100ps
`default_nettype none

module programCounter
(
    input  logic                         clk,
    input  logic                         reset,
    output logic [cpuPkg::instWidth-1:0] pc
);
    import cpuPkg::*;

    // Straight-line fetch, no branch target
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= '0;
        end
        else
        begin
            pc <= pc + pcStep;
        end
    end

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile
(
    input  logic                             clk,
    input  logic [cpuPkg::regIndexWidth-1:0] readA,
    input  logic [cpuPkg::regIndexWidth-1:0] readB,
    output logic [cpuPkg::dataWidth-1:0]     dataA,
    output logic [cpuPkg::dataWidth-1:0]     dataB,
    input  logic                             writeEnable,
    input  logic [cpuPkg::regIndexWidth-1:0] writeIndex,
    input  logic [cpuPkg::dataWidth-1:0]     writeData
);
    import cpuPkg::*;

    // XZR has no storage
    logic [dataWidth-1:0] regs [0:regCount-2];
    logic                 writeLive;

    assign writeLive = writeEnable && (writeIndex != zeroReg);

    always_ff @(posedge clk)
    begin
        if (writeLive)
        begin
            regs[writeIndex] <= writeData;
        end
    end

    // Write-back data is visible to ID in the same cycle
    assign dataA = (readA == zeroReg) ? '0 :
                   (writeLive && (readA == writeIndex)) ? writeData : regs[readA];
    assign dataB = (readB == zeroReg) ? '0 :
                   (writeLive && (readB == writeIndex)) ? writeData : regs[readB];

endmodule

`default_nettype wire

//--- tests/cpuCoreChecker.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCoreChecker
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [cpuPkg::instWidth-1:0] iaddrbus,
    input  logic [cpuPkg::dataWidth-1:0] daddrbus,
    input  logic [cpuPkg::dataWidth-1:0] dataOut,
    input  logic                         memWrite
);
    import cpuPkg::*;

    // Stores in program order, filled by the testbench model
    logic [dataWidth-1:0] expAddr [$];
    logic [dataWidth-1:0] expData [$];
    logic [instWidth-1:0] expPc     = '0;
    logic                 resetSeen = 1'b0;
    int                   errors    = 0;
    int                   stores    = 0;

    task automatic expectStore(input logic [dataWidth-1:0] addr,
                               input logic [dataWidth-1:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic compareStore();
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        if (expAddr.size() == 0)
        begin
            $display("Store to address %h at %0t with no store left to expect", daddrbus, $time);
            errors++;
        end
        else
        begin
            addr = expAddr.pop_front();
            data = expData.pop_front();
            stores++;
            if (daddrbus !== addr)
            begin
                $display("[FAIL] daddrbus store %0d: got %h, expected %h", stores, daddrbus, addr);
                errors++;
            end
            if (dataOut !== data)
            begin
                $display("[FAIL] dataOut store %0d: got %h, expected %h", stores, dataOut, data);
                errors++;
            end
        end
    endtask

    // Values seen here are the ones held through the cycle that just ended
    always @(posedge clk)
    begin
        if (resetSeen)
        begin
            if (memWrite === 1'b1)
            begin
                compareStore();
            end
            else if (memWrite !== 1'b0)
            begin
                $display("memWrite is neither high nor low at %0t", $time);
                errors++;
            end
        end
        if (reset)
        begin
            resetSeen = 1'b1;
            expPc     = '0;
        end
        else if (resetSeen)
        begin
            if (iaddrbus !== expPc)
            begin
                $display("[FAIL] iaddrbus: got %h, expected %h", iaddrbus, expPc);
                errors++;
            end
            expPc = expPc + 32'd4;
        end
    end

    // Anything still queued never reached the port
    task automatic reportTotals(output int errorTotal, output int storeTotal);
        if (expAddr.size() != 0)
        begin
            $display("%0d expected stores never appeared on the memory port", expAddr.size());
            errors++;
        end
        errorTotal = errors;
        storeTotal = stores;
    endtask

endmodule

`default_nettype wire

//--- tests/cpuCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuCoreTb;
    import cpuPkg::*;

    localparam int progLen     = 200;
    localparam int resetCycles = 3;
    localparam int drainSlots  = 4;
    localparam int memWords    = 128;
    localparam int clkPeriod   = 8;

    // Opcode tables indexed like the model's operation number
    localparam logic [6:0][opcodeWidth-1:0] rOps = {opLsr, opLsl, opEor, opOrr, opAnd, opSub, opAdd};
    localparam logic [4:0][opcodeWidth-1:0] iOps = {opEori, opOrri, opAndi, opSubi, opAddi};

    logic                 clk;
    logic                 reset;
    logic [instWidth-1:0] ibus;
    logic [instWidth-1:0] iaddrbus;
    logic [dataWidth-1:0] daddrbus;
    logic [dataWidth-1:0] dataOut;
    logic [dataWidth-1:0] dataIn;
    logic                 memWrite;

    logic [instWidth-1:0] progMem   [0:progLen-1];
    logic [dataWidth-1:0] dataMem   [0:memWords-1];
    logic [dataWidth-1:0] modelMem  [0:memWords-1];
    logic [dataWidth-1:0] modelRegs [0:regCount-1];
    integer               seed;
    int                   lastA;
    int                   lastB;
    int                   lastStoreRn;
    logic [8:0]           lastStoreOff;
    int                   expectedStores;
    int                   errors;
    int                   stores;

    cpuCore dut_i
    (
        .clk      (clk),
        .reset    (reset),
        .ibus     (ibus),
        .iaddrbus (iaddrbus),
        .daddrbus (daddrbus),
        .dataOut  (dataOut),
        .dataIn   (dataIn),
        .memWrite (memWrite)
    );

    cpuCoreChecker checker_i
    (
        .clk      (clk),
        .reset    (reset),
        .iaddrbus (iaddrbus),
        .daddrbus (daddrbus),
        .dataOut  (dataOut),
        .memWrite (memWrite)
    );

    // Both memories answer combinationally
    assign ibus   = (iaddrbus[instWidth-1:2] < progLen) ? progMem[iaddrbus[instWidth-1:2]] : '0;
    assign dataIn = dataMem[daddrbus[9:3]];

    always @(posedge clk)
    begin
        if (memWrite === 1'b1)
        begin
            dataMem[daddrbus[9:3]] <= dataOut;
        end
    end

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    function automatic logic [dataWidth-1:0] fillWord(input int idx);
        return {32'(idx) ^ 32'hc0de5a5a, 32'(idx * 32'h9e3779b9)};
    endfunction

    function automatic logic [instWidth-1:0] encodeR(input logic [opcodeWidth-1:0] op,
        input logic [4:0] rm, input logic [5:0] shamt, input logic [4:0] rn, input logic [4:0] rd);
        return {op, rm, shamt, rn, rd};
    endfunction

    function automatic logic [instWidth-1:0] encodeI(input logic [opcodeWidth-1:0] op,
        input logic [11:0] imm, input logic [4:0] rn, input logic [4:0] rd);
        return {op[10:1], imm, rn, rd};
    endfunction

    function automatic logic [instWidth-1:0] encodeD(input logic [opcodeWidth-1:0] op,
        input logic [8:0] off, input logic [4:0] rn, input logic [4:0] rt);
        return {op, off, 2'b00, rn, rt};
    endfunction

    function automatic logic [dataWidth-1:0] readReg(input logic [4:0] idx);
        return (idx == 5'd31) ? '0 : modelRegs[idx];
    endfunction

    // 0 add, 1 sub, 2 and, 3 orr, 4 eor, 5 lsl, 6 lsr
    function automatic logic [dataWidth-1:0] aluModel(input int sel,
        input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
        case (sel)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return a << b[5:0];
            6: return a >> b[5:0];
            default: return '0;
        endcase
    endfunction

    // Keeps clear of the two most recent destinations
    task automatic pickSource(output logic [4:0] r);
        r = 5'($random(seed));
        while (r == lastA || r == lastB)
        begin
            r = 5'($random(seed));
        end
    endtask

    task automatic buildProgram();
        logic [4:0]           rd;
        logic [4:0]           rn;
        logic [4:0]           rm;
        logic [11:0]          imm;
        logic [8:0]           off;
        logic [5:0]           shamt;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] result;
        int                   kind;
        int                   sel;
        for (int i = 0; i < 31; i++)
        begin
            imm          = 12'($random(seed));
            progMem[i]   = encodeI(opAddi, imm, 5'd31, 5'(i));
            modelRegs[i] = {52'b0, imm};
        end
        lastA = 30;
        lastB = 29;
        for (int i = 31; i < progLen; i++)
        begin
            kind = $unsigned($random(seed)) % 10;
            rd   = 5'($random(seed));
            if (($random(seed) & 7) == 0)
            begin
                rd = 5'd31;
            end
            imm = 12'($random(seed));
            off = 9'($random(seed));
            pickSource(rn);
            pickSource(rm);
            // Loads often revisit the last store location
            if (kind == 5 && imm[0] && lastStoreRn >= 0 && lastStoreRn != lastA &&
                lastStoreRn != lastB)
            begin
                rn  = 5'(lastStoreRn);
                off = lastStoreOff;
            end
            a    = readReg(rn);
            b    = readReg(rm);
            addr = a + {{(dataWidth-9){off[8]}}, off};
            if (kind < 3)
            begin
                sel   = $unsigned($random(seed)) % 7;
                shamt = (sel >= 5) ? imm[5:0] : 6'd0;
                if (sel >= 5)
                begin
                    b = {58'b0, shamt};
                end
                progMem[i] = encodeR(rOps[sel], rm, shamt, rn, rd);
                result     = aluModel(sel, a, b);
            end
            else if (kind < 5)
            begin
                sel        = $unsigned($random(seed)) % 5;
                progMem[i] = encodeI(iOps[sel], imm, rn, rd);
                result     = aluModel(sel, a, {52'b0, imm});
            end
            else if (kind == 5)
            begin
                progMem[i] = encodeD(opLdur, off, rn, rd);
                result     = modelMem[addr[9:3]];
            end
            else
            begin
                progMem[i]          = encodeD(opStur, off, rn, rm);
                modelMem[addr[9:3]] = b;
                checker_i.expectStore(addr, b);
                expectedStores++;
                lastStoreRn  = rn;
                lastStoreOff = off;
            end
            if (kind < 6 && rd != 5'd31)
            begin
                modelRegs[rd] = result;
            end
            lastB = lastA;
            lastA = (kind < 6) ? int'(rd) : -1;
        end
    endtask

    initial
    begin
        seed           = 32'h91d6c96f;
        lastStoreRn    = -1;
        lastStoreOff   = '0;
        expectedStores = 0;
        reset          = 1'b1;
        for (int w = 0; w < memWords; w++)
        begin
            dataMem[w]  = fillWord(w);
            modelMem[w] = fillWord(w);
        end
        buildProgram();
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // Fixed three-slot latency to the memory port, then one spare
        while (iaddrbus < (progLen + drainSlots) * 4)
        begin
            @(posedge clk);
        end
        // Checker settles the final edge first
        @(negedge clk);
        checker_i.reportTotals(errors, stores);
        $display("Stores checked %0d of %0d, errors %0d", stores, expectedStores, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial
    begin
        #((progLen + resetCycles + drainSlots + 20) * clkPeriod);
        $display("Timeout, the program did not drain through the pipeline in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
